// File: verilog/clkgen_cfg_pkg.sv
////////////////////////////////////////////////////////////
// Sizing of the generator datapath
////////////////////////////////////////////////////////////
package clkgen_cfg_pkg;

	// Output clock samples produced per system cycle
	localparam int WORD_W = 8;

	// Phase accumulator width, wraps modulo 2^PHASE_W
	localparam int PHASE_W = 32;

	// Quiet interval after each frequency load
	localparam int SETTLE_CYCLES = 16;
	localparam int TIMER_W = 5;
	// Counter value loaded on start, counts down to zero
	localparam logic [TIMER_W-1:0] SETTLE_LAST = TIMER_W'(SETTLE_CYCLES - 1);

	// Register stages between generator and serializer
	localparam int SER_DELAY = 2;

endpackage

// File: verilog/clkgen_types_pkg.sv
////////////////////////////////////////////////////////////
// Bundles that move between the generator blocks
////////////////////////////////////////////////////////////
package clkgen_types_pkg;

	// One frequency command
	// load is a single cycle strobe, step is the phase increment
	// per output sample
	typedef struct packed {
		logic                                load;
		logic [clkgen_cfg_pkg::PHASE_W-1:0] step;
	} freq_cmd_t;

	// One word of consecutive clock samples
	// Bit WORD_W-1 is the earliest sample and goes out first
	typedef struct packed {
		logic                               valid;
		logic [clkgen_cfg_pkg::WORD_W-1:0] word;
	} gen_word_t;

endpackage

// File: verilog/pipe_delay.sv
`timescale 1ns/1ps

// Fixed latency register chain for any packed payload
module pipe_delay #(
	parameter type T = logic,
	parameter int DEPTH = 1
) (
	input  logic i_clk,
	input  logic i_rst,
	input  T     i_d,
	output T     o_q
);

	// Stage 0 takes the input, last stage drives the output
	T stage_q [DEPTH];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			// Clearing the whole payload also drops any valid flag
			for (int i = 0; i < DEPTH; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= i_d;
			for (int i = 1; i < DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign o_q = stage_q[DEPTH-1];

	// A zero depth chain has no register to hold the payload
	if (DEPTH < 1) begin : g_depth_chk
		$error("pipe_delay needs DEPTH of at least 1");
	end

endmodule

// File: verilog/settle_timer.sv
`timescale 1ns/1ps

// Down counter that marks the end of the settle interval
module settle_timer (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_start,
	output logic o_done
);

	logic [clkgen_cfg_pkg::TIMER_W-1:0] cnt_q;
	logic                               busy_q;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			cnt_q  <= '0;
			busy_q <= 1'b0;
		end else if (i_start) begin
			// Restart from the top even when already counting
			cnt_q  <= clkgen_cfg_pkg::SETTLE_LAST;
			busy_q <= 1'b1;
		end else if (busy_q) begin
			if (cnt_q == '0) begin
				busy_q <= 1'b0;
			end else begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	// Last cycle of the interval
	// The controller moves on at the edge that sees this high
	assign o_done = busy_q && (cnt_q == '0);

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Done only closes an interval started SETTLE_CYCLES cycles back
	a_no_done_idle: assert property (@(posedge i_clk) disable iff (i_rst)
		o_done |-> $past(i_start, clkgen_cfg_pkg::SETTLE_CYCLES));

endmodule

// File: verilog/freq_ctrl_fsm.sv
`timescale 1ns/1ps

// Sequencer for frequency loads
// IDLE waits for a load, SETTLE holds the accumulator at zero,
// RUN lets the generator free-run until stop or a new load
module freq_ctrl_fsm (
	input  logic                               i_clk,
	input  logic                               i_rst,
	input  clkgen_types_pkg::freq_cmd_t        i_cmd,
	input  logic                               i_stop,
	output logic [clkgen_cfg_pkg::PHASE_W-1:0] o_step,
	output logic                               o_acc_clear,
	output logic                               o_run
);

	typedef enum logic [1:0] {
		IDLE,
		SETTLE,
		RUN
	} state_t;

	state_t                             state_q;
	logic [clkgen_cfg_pkg::PHASE_W-1:0] step_q;
	logic                               timer_done;

	// Timer restarts on the same edge that enters SETTLE
	settle_timer u_timer (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (i_cmd.load),
		.o_done  (timer_done)
	);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_q <= IDLE;
		end else if (i_cmd.load) begin
			// Load wins over stop in every state
			state_q <= SETTLE;
		end else begin
			case (state_q)
				SETTLE: begin
					if (i_stop) begin
						state_q <= IDLE;
					end else if (timer_done) begin
						state_q <= RUN;
					end
				end
				RUN: begin
					if (i_stop) begin
						state_q <= IDLE;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// Step held for the whole run
	always_ff @(posedge i_clk) begin
		if (i_cmd.load) begin
			step_q <= i_cmd.step;
		end
	end

	assign o_step      = step_q;
	assign o_acc_clear = (state_q == SETTLE);
	assign o_run       = (state_q == RUN);

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	a_run_xor_clear: assert property (@(posedge i_clk) disable iff (i_rst)
		!(o_run && o_acc_clear));

	// RUN starts one cycle plus a full settle interval after the last load
	a_run_after_settle: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(o_run) |-> $past(i_cmd.load, clkgen_cfg_pkg::SETTLE_CYCLES + 1));

endmodule

// File: verilog/phase_word_gen.sv
`timescale 1ns/1ps

// Numerically controlled oscillator, WORD_W samples per cycle
// Sample k of a word is the accumulator MSB at acc + k*step
module phase_word_gen (
	input  logic                               i_clk,
	input  logic                               i_rst,
	input  logic [clkgen_cfg_pkg::PHASE_W-1:0] i_step,
	input  logic                               i_clear,
	input  logic                               i_run,
	output clkgen_types_pkg::gen_word_t        o_word
);

	logic [clkgen_cfg_pkg::PHASE_W-1:0] acc_q;
	// Phase of each sample within the current word
	logic [clkgen_cfg_pkg::PHASE_W-1:0] phase_k [clkgen_cfg_pkg::WORD_W];
	logic [clkgen_cfg_pkg::WORD_W-1:0]  samples;

	// Chain of adders, one step apart
	always_comb begin
		phase_k[0] = acc_q;
		for (int k = 1; k < clkgen_cfg_pkg::WORD_W; k++) begin
			phase_k[k] = phase_k[k-1] + i_step;
		end
	end

	// Earliest sample lands in the MSB
	always_comb begin
		for (int k = 0; k < clkgen_cfg_pkg::WORD_W; k++) begin
			samples[clkgen_cfg_pkg::WORD_W-1-k] = phase_k[k][clkgen_cfg_pkg::PHASE_W-1];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			acc_q <= '0;
		end else if (i_clear) begin
			acc_q <= '0;
		end else if (i_run) begin
			// Next word starts one step past the last sample
			// Wraps modulo 2^PHASE_W
			acc_q <= phase_k[clkgen_cfg_pkg::WORD_W-1] + i_step;
		end
	end

	// Registered word, zero whenever the generator is halted
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_word <= '0;
		end else begin
			o_word.valid <= i_run;
			o_word.word  <= i_run ? samples : '0;
		end
	end

endmodule

// File: verilog/word_serializer.sv
`timescale 1ns/1ps

// SDR serializer model
// Words are delayed two system cycles, then each is shifted out
// MSB first during the following system cycle on the bit clock
module word_serializer (
	input  logic                        i_clk,
	input  logic                        i_serclk,
	input  logic                        i_rst,
	input  clkgen_types_pkg::gen_word_t i_word,
	output clkgen_types_pkg::gen_word_t o_word,
	output logic [1:0]                  o_pin
);

	logic [2:0]                        ph_q;
	logic [clkgen_cfg_pkg::WORD_W-1:0] shift_q;

	// Word and its valid flag travel together through the delay
	pipe_delay #(
		.T     (clkgen_types_pkg::gen_word_t),
		.DEPTH (clkgen_cfg_pkg::SER_DELAY)
	) u_word_dly (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_d   (i_word),
		.o_q   (o_word)
	);

	////////////////////////////////////////////////////////////
	// Bit clock domain
	////////////////////////////////////////////////////////////

	// Phase counter
	// Reset leaves it at 1 so that the eighth bit edge after the
	// release lines up with the next system edge at phase 0
	always_ff @(posedge i_serclk) begin
		if (i_rst) begin
			ph_q <= 3'd1;
		end else begin
			ph_q <= ph_q + 3'd1;
		end
	end

	// Phase 0 coincides with the system edge, so the load still
	// sees the word of the cycle that just ended
	always_ff @(posedge i_serclk) begin
		if (i_rst) begin
			shift_q <= '0;
		end else if (ph_q == 3'd0) begin
			shift_q <= o_word.valid ? o_word.word : '0;
		end else begin
			shift_q <= shift_q << 1;
		end
	end

	// Pin pair, true bit on 1 and complement on 0
	assign o_pin[1] = shift_q[clkgen_cfg_pkg::WORD_W-1];
	assign o_pin[0] = ~shift_q[clkgen_cfg_pkg::WORD_W-1];

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// First half of the count sits in the high half of i_clk
	// Phases 0 and 4 share an edge with i_clk and are skipped
	a_phase_aligned: assert property (@(posedge i_serclk) disable iff (i_rst)
		(ph_q != 3'd0 && ph_q != 3'd4) |-> (i_clk == (ph_q < 3'd4)));

endmodule

// File: verilog/clkgen_top.sv
`timescale 1ns/1ps

// Programmable clock generator
// Command register, controller, phase generator and serializer
module clkgen_top (
	input  logic                        i_clk,
	// Bit clock, 8x i_clk and rising with it
	input  logic                        i_serclk,
	input  logic                        i_rst,
	input  clkgen_types_pkg::freq_cmd_t i_cmd,
	input  logic                        i_stop,
	output clkgen_types_pkg::gen_word_t o_word,
	// Bit 1 true output, bit 0 inverted
	output logic [1:0]                  o_pin
);

	// Registered command
	clkgen_types_pkg::freq_cmd_t cmd_q;

	// Controller to generator
	logic [clkgen_cfg_pkg::PHASE_W-1:0] step;
	logic                               acc_clear;
	logic                               run;

	// Generator to serializer
	clkgen_types_pkg::gen_word_t gen_word;

	////////////////////////////////////////////////////////////
	// Command input stage
	////////////////////////////////////////////////////////////

	pipe_delay #(
		.T     (clkgen_types_pkg::freq_cmd_t),
		.DEPTH (1)
	) u_cmd_dly (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_d   (i_cmd),
		.o_q   (cmd_q)
	);

	// Load and stop sequencing, holds the active step
	freq_ctrl_fsm u_ctrl (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_cmd       (cmd_q),
		.i_stop      (i_stop),
		.o_step      (step),
		.o_acc_clear (acc_clear),
		.o_run       (run)
	);

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	phase_word_gen u_gen (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_step  (step),
		.i_clear (acc_clear),
		.i_run   (run),
		.o_word  (gen_word)
	);

	// o_word is the delayed word that the shifter loads
	word_serializer u_ser (
		.i_clk    (i_clk),
		.i_serclk (i_serclk),
		.i_rst    (i_rst),
		.i_word   (gen_word),
		.o_word   (o_word),
		.o_pin    (o_pin)
	);

endmodule

// File: dv/clkgen_tb.sv
`timescale 1ns/1ps

module clkgen_tb;

	// Bounds for every wait loop, in system cycles
	localparam int RISE_LIMIT = 64;
	localparam int DROP_LIMIT = 16;
	// Sampling edge of a load to the first valid o_word
	localparam int LOAD_LAT = clkgen_cfg_pkg::SETTLE_CYCLES + 4;
	// Command register, then the same path as a stop
	localparam int RELOAD_DROP = 4;
	localparam int STOP_DROP = 3;

	logic                        i_clk;
	logic                        i_serclk;
	logic                        i_rst;
	clkgen_types_pkg::freq_cmd_t i_cmd;
	logic                        i_stop;
	clkgen_types_pkg::gen_word_t o_word;
	logic [1:0]                  o_pin;

	integer seed;
	int     err_cnt;
	int     test_cnt;
	int     fail_cnt;
	// Bits rebuilt from the pin and the o_word history they must match
	logic [7:0]                  rx_bits;
	logic [7:0]                  ser_word;
	clkgen_types_pkg::gen_word_t hist1;
	clkgen_types_pkg::gen_word_t hist2;

	clkgen_top dut (
		.i_clk    (i_clk),
		.i_serclk (i_serclk),
		.i_rst    (i_rst),
		.i_cmd    (i_cmd),
		.i_stop   (i_stop),
		.o_word   (o_word),
		.o_pin    (o_pin)
	);

	////////////////////////////////////////////////////////////
	// Clocks, bit clock rises together with i_clk
	////////////////////////////////////////////////////////////

	always #10 i_clk = ~i_clk;
	always #1.25 i_serclk = ~i_serclk;

	// Mid-bit sampling of the pin pair
	always @(negedge i_serclk) begin
		if (i_rst) begin
			rx_bits = '0;
		end else begin
			rx_bits = {rx_bits[6:0], o_pin[1]};
			if (o_pin[0] !== ~o_pin[1]) begin
				$display("[ERROR] %0t: o_pin[0] not inverse of o_pin[1], pins %b", $time, o_pin);
				err_cnt++;
			end
		end
	end

	// Eight bits of the cycle that just ended
	always @(posedge i_clk) begin
		ser_word = rx_bits;
	end

	// Word idx counted from phase zero, sample k at phase step*(8*idx+k)
	function automatic logic [7:0] model_word(input logic [31:0] step, input int idx);
		logic [31:0] phase;
		logic [7:0]  w;
		for (int k = 0; k < clkgen_cfg_pkg::WORD_W; k++) begin
			phase = step * 32'(clkgen_cfg_pkg::WORD_W * idx + k);
			// Earliest sample is the MSB
			w[7-k] = phase[31];
		end
		return w;
	endfunction

	// One system cycle, ends 2 ns after the edge
	// Pins of the last cycle carry o_word from two edges back
	task automatic step_cycle();
		logic [7:0] exp_ser;
		@(posedge i_clk);
		#2;
		exp_ser = hist2.valid ? hist2.word : 8'h00;
		if (ser_word !== exp_ser) begin
			$display("[ERROR] %0t: serial bits %h, expected %h", $time, ser_word, exp_ser);
			err_cnt++;
		end
		hist2 = hist1;
		hist1 = o_word;
	endtask

	task automatic wait_valid(input logic lvl, input int start, input int limit,
		input string what, output int n);
		n = start;
		while (o_word.valid !== lvl && n < limit) begin
			step_cycle();
			n++;
		end
		if (o_word.valid !== lvl) begin
			$display("Timeout: o_word valid did not %s within %0d cycles", what, limit);
			err_cnt++;
		end
	endtask

	task automatic do_load(input logic [31:0] step, input int nwords, input bit reload);
		int         n;
		bit         was_run;
		logic [7:0] exp;
		was_run = (o_word.valid === 1'b1);
		if (reload && !was_run) begin
			$display("Reload issued while the output was not running");
			err_cnt++;
		end
		i_cmd.load = 1'b1;
		i_cmd.step = step;
		step_cycle();
		i_cmd.load = 1'b0;
		n = 0;
		// Running output drops first
		if (was_run) begin
			wait_valid(1'b0, 0, DROP_LIMIT, "fall", n);
			if (o_word.valid === 1'b0 && n != RELOAD_DROP) begin
				$display("[ERROR] %0t: valid fell after %0d cycles, expected %0d",
					$time, n, RELOAD_DROP);
				err_cnt++;
			end
		end
		wait_valid(1'b1, n, RISE_LIMIT, "rise", n);
		if (o_word.valid !== 1'b1) begin
			return;
		end
		if (n != LOAD_LAT) begin
			$display("[ERROR] %0t: valid rose after %0d cycles, expected %0d", $time, n, LOAD_LAT);
			err_cnt++;
		end
		for (int j = 0; j < nwords; j++) begin
			exp = model_word(step, j);
			if (o_word.valid !== 1'b1 || o_word.word !== exp) begin
				$display("[ERROR] %0t: word %0d is %b/%h, expected 1/%h",
					$time, j, o_word.valid, o_word.word, exp);
				err_cnt++;
			end
			step_cycle();
		end
	endtask

	task automatic do_stop();
		int n;
		i_stop = 1'b1;
		step_cycle();
		i_stop = 1'b0;
		wait_valid(1'b0, 0, DROP_LIMIT, "fall", n);
		if (o_word.valid === 1'b0 && n != STOP_DROP) begin
			$display("[ERROR] %0t: valid fell after %0d cycles, expected %0d", $time, n, STOP_DROP);
			err_cnt++;
		end
		// Last valid word still leaves the pins in the next cycle
		repeat (2) step_cycle();
		repeat (4) begin
			step_cycle();
			if (o_pin !== 2'b01) begin
				$display("[ERROR] %0t: idle pins %b, expected 01", $time, o_pin);
				err_cnt++;
			end
		end
	endtask

	task automatic report_test(input int id, input string name, input int err_before);
		test_cnt++;
		if (err_cnt == err_before) begin
			$display("test %0d %s: pass", id, name);
		end else begin
			fail_cnt++;
			$display("test %0d %s: fail, %0d errors", id, name, err_cnt - err_before);
		end
	endtask

	initial begin
		int          fd;
		int          rc;
		int          id;
		int          op;
		int          cnt;
		int          e0;
		logic [31:0] stp;
		string       line;
		string       name;
		seed     = 32'h7794_b0ac;
		i_clk    = 1'b0;
		i_serclk = 1'b1;
		i_rst    = 1'b1;
		i_cmd    = '0;
		i_stop   = 1'b0;
		err_cnt  = 0;
		test_cnt = 0;
		fail_cnt = 0;
		rx_bits  = '0;
		ser_word = '0;
		hist1    = '0;
		hist2    = '0;
		repeat (3) @(posedge i_clk);
		#2;
		i_rst = 1'b0;

		// Quiet outputs before any command
		e0 = err_cnt;
		repeat (4) begin
			step_cycle();
			if (o_word.valid !== 1'b0 || o_pin !== 2'b01) begin
				$display("[ERROR] %0t: after reset valid %b pins %b", $time, o_word.valid, o_pin);
				err_cnt++;
			end
		end
		report_test(0, "idle after reset", e0);

		////////////////////////////////////////////////////////////
		// Trace driven tests
		////////////////////////////////////////////////////////////
		fd = $fopen("dv/clkgen_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file dv/clkgen_trace.txt");
			err_cnt++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line[0] == "#") begin
					continue;
				end
				e0 = err_cnt;
				rc = $sscanf(line, "%d %d %h %d", id, op, stp, cnt);
				if (rc != 4) begin
					$display("Malformed trace line: %s", line);
					err_cnt++;
					continue;
				end
				case (op)
					1: begin
						name = "load";
						do_load(stp, cnt, 1'b0);
					end
					2: begin
						name = "reload";
						do_load(stp, cnt, 1'b1);
					end
					3: begin
						name = "stop";
						do_stop();
					end
					default: begin
						name = "unknown";
						$display("Unknown opcode %0d in trace test %0d", op, id);
						err_cnt++;
					end
				endcase
				report_test(id, name, e0);
			end
			$fclose(fd);
		end

		// One extra load with a random step
		e0 = err_cnt;
		stp = $random(seed);
		$display("random step %h", stp);
		do_load(stp, 16, 1'b0);
		report_test(test_cnt, "random step", e0);

		$display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: clkgen.f
verilog/clkgen_cfg_pkg.sv
verilog/clkgen_types_pkg.sv
verilog/pipe_delay.sv
verilog/settle_timer.sv
verilog/freq_ctrl_fsm.sv
verilog/phase_word_gen.sv
verilog/word_serializer.sv
verilog/clkgen_top.sv
dv/clkgen_tb.sv

// File: Makefile
# Verilator build and run for the clock generator testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= clkgen_tb
FILELIST  ?= clkgen.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/clkgen_trace.txt
# test_id opcode step_hex word_count
# opcode 1 load from idle, 2 reload while running, 3 stop
1 1 10000000 12
2 2 7fffff00 16
3 2 02000000 24
4 3 00000000 0
5 1 55555555 12
6 2 c0000000 8
7 3 00000000 0
